// File: huffman_stream_decoder.f
+incdir+common
+incdir+tests
common/huffman_pkg.sv
huffman_core/decode_sequencer.sv
huffman_core/bit_window.sv
huffman_core/code_matcher.sv
huffman_core/symbol_lookup.sv
verilog/symbol_emitter.sv
verilog/huffman_stream_decoder.sv
tests/tb_huffman.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log \
   && verilator --binary --assert --timescale 1ns/100ps --top-module tb_huffman \
      -f huffman_stream_decoder.f -o tb_huffman \
   && ./obj_dir/tb_huffman | tee sim.log \
   && grep -q "^STATUS: PASS$" sim.log \
   && echo "run_sim: simulation passed" \
   || { echo "run_sim: simulation failed"; exit 1; }

// File: tests/tb_huffman_stim.svh
`ifndef TB_HUFFMAN_STIM_SVH
`define TB_HUFFMAN_STIM_SVH

// Galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] galois_step(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// one LFSR step per bit taken, first bit lands in the MSB
function automatic int take_bits(input int n);
   int v;
   int i;
   v = 0;
   for (i = 0; i < n; i++)
   begin
      msg_rng = galois_step(msg_rng);
      v = (v << 1) | int'(msg_rng[0]);
   end
   return v;
endfunction

task automatic add_random_message(input int n);
   int i;
   for (i = 0; i < n; i++)
      msg.push_back(sym_t'(take_bits(3)));  // A..H only
   msg.push_back(sym_t'(`HUF_EOM));
endtask

task automatic idle_after_reset;
   begin_test("reset_idle");
   repeat (20)
   begin
      @(posedge clk);
      assert (!push && !pop && !decode_error)
         else flag_error("strobe active while no word was offered");
   end
   finish_test();
endtask

// A..H plus EOM is exactly 32 bits, so no padding
task automatic every_symbol_message;
   int s;
   begin_test("every_symbol");
   for (s = 0; s < 8; s++)
      msg.push_back(sym_t'(s));
   msg.push_back(sym_t'(`HUF_EOM));
   queue_message();
   finish_test();
endtask

task automatic straddled_codes;
   int i;
   begin_test("straddle");
   for (i = 0; i < 60; i++)
      msg.push_back(sym_t'((i * 5 + 3) % 8));
   msg.push_back(sym_t'(`HUF_EOM));
   queue_message();
   finish_test();
endtask

task automatic random_backpressure;
   begin_test("backpressure");
   stall_mode <= 1'b1;
   add_random_message(40);
   add_random_message(25);
   queue_message();
   finish_test();
   stall_mode <= 1'b0;
endtask

// short message leaves 23 padding bits, the second one fills its word
task automatic eom_with_padding;
   int s;
   begin_test("eom_padding");
   msg.push_back(sym_t'(4));
   msg.push_back(sym_t'(7));
   msg.push_back(sym_t'(`HUF_EOM));
   for (s = 7; s >= 0; s--)
      msg.push_back(sym_t'(s));
   msg.push_back(sym_t'(`HUF_EOM));
   queue_message();
   finish_test();
endtask

task automatic random_messages;
   int m;
   begin_test("random_msgs");
   for (m = 0; m < 50; m++)
      add_random_message(1 + take_bits(5));
   queue_message();
   finish_test();
endtask

`endif

// File: tests/tb_huffman.sv
`include "huffman_cfg.svh"

module tb_huffman;
   timeunit 1ns;
   timeprecision 100ps;

   import huffman_pkg::*;

   logic                   clk = 1'b0;
   logic                   reset = 1'b1;
   logic [`HUF_WORD_W-1:0] word = '0;
   logic                   rdy = 1'b0;
   logic                   not_full = 1'b1;
   logic                   pop;
   logic                   push;
   sym_t                   symbol;
   logic                   decode_error;

   logic [`HUF_WORD_W-1:0] word_q[$];  // upstream FIFO contents, never emptied
   logic [`HUF_SYM_W:0]    exp_q[$];   // {decode_error, symbol} per push
   logic [`HUF_SYM_W:0]    exp_item;
   sym_t                   msg[$];
   int                     rd_ptr = 0;
   logic                   stall_mode = 1'b0;
   logic [31:0]            stall_rng = 32'hf178b072;
   logic [31:0]            msg_rng = 32'hf178b072;
   logic                   nf_last = 1'b1;
   string                  cur_test = "none";
   int                     test_syms = 0;
   int                     err_at_start = 0;
   int                     error_count = 0;
   int                     check_count = 0;
   int                     tests_run = 0;
   int                     cycle_count = 0;
   int                     cycle_budget = 100;  // reset plus idle check

   `include "tb_huffman_stim.svh"

   huffman_stream_decoder u_dut
   (
      .clk          (clk),
      .reset        (reset),
      .word         (word),
      .rdy          (rdy),
      .pop          (pop),
      .not_full     (not_full),
      .push         (push),
      .symbol       (symbol),
      .decode_error (decode_error)
   );

   initial forever #2 clk = ~clk;

   // show-ahead upstream FIFO
   always @(posedge clk)
   begin
      if (pop)
         rd_ptr = rd_ptr + 1;
      rdy <= rd_ptr < word_q.size();
      if (rd_ptr < word_q.size())
         word <= word_q[rd_ptr];
   end

   always @(posedge clk)
   begin
      if (stall_mode)
      begin
         stall_rng = galois_step(stall_rng);
         not_full <= stall_rng[0];  // downstream fill level
      end
      else
         not_full <= 1'b1;
   end

   // prefix code as {length, code right aligned}
   function automatic logic [7:0] code_for(input sym_t s);
      case (s)
         4'd0:    return {3'd3, 5'b00100};
         4'd1:    return {3'd5, 5'b11110};
         4'd2:    return {3'd4, 5'b01100};
         4'd3:    return {3'd3, 5'b00101};
         4'd4:    return {3'd2, 5'b00000};
         4'd5:    return {3'd4, 5'b01101};
         4'd6:    return {3'd4, 5'b01110};
         4'd7:    return {3'd2, 5'b00001};
         default: return {3'd5, 5'b11111};  // EOM
      endcase
   endfunction

   // MSB first, zero padded to a word boundary after each EOM
   function automatic int encode_words(input sym_t syms[$]);
      logic [31:0] acc;
      logic [7:0]  code;
      logic [4:0]  bits;
      int          nbits;
      int          nwords;
      acc    = '0;
      nbits  = 0;
      nwords = 0;
      foreach (syms[i])
      begin
         code = code_for(syms[i]);
         bits = code[4:0] << (5 - int'(code[7:5]));
         repeat (int'(code[7:5]))
         begin
            acc   = {acc[30:0], bits[4]};
            bits  = bits << 1;
            nbits = nbits + 1;
            if (nbits == 32)
            begin
               word_q.push_back(acc);
               nwords = nwords + 1;
               nbits  = 0;
            end
         end
         if (syms[i] == sym_t'(`HUF_EOM) && nbits != 0)
         begin
            word_q.push_back(acc << (32 - nbits));
            nwords = nwords + 1;
            nbits  = 0;
         end
      end
      return nwords;
   endfunction

   // error expected with EOM whenever its word still holds padding
   function automatic void expect_symbols(input sym_t syms[$]);
      logic [7:0] code;
      int         pos;
      pos = 0;
      foreach (syms[i])
      begin
         code = code_for(syms[i]);
         pos  = (pos + int'(code[7:5])) % 32;
         exp_q.push_back({syms[i] == sym_t'(`HUF_EOM) && pos != 0, syms[i]});
         if (syms[i] == sym_t'(`HUF_EOM))
            pos = 0;  // next message on a fresh word
      end
   endfunction

   task automatic flag_error(input string what);
      $display("ERROR test=%s: %s", cur_test, what);
      error_count = error_count + 1;
   endtask

   task automatic report_mismatch(input string what, input int expected, input int actual);
      $display("MISMATCH test=%s %s expected=%0d actual=%0d", cur_test, what, expected, actual);
      error_count = error_count + 1;
   endtask

   task automatic queue_message;
      int nwords;
      nwords = encode_words(msg);
      expect_symbols(msg);
      cycle_budget = cycle_budget + 12 * msg.size() + 40 * nwords;
      test_syms    = test_syms + msg.size();
      msg.delete();
   endtask

   task automatic begin_test(input string name);
      cur_test     = name;
      err_at_start = error_count;
      test_syms    = 0;
      cycle_budget = cycle_budget + 20;  // trailing idle cycles
   endtask

   task automatic finish_test;
      while (exp_q.size() != 0)
         @(posedge clk);
      repeat (8) @(posedge clk);
      assert (rd_ptr == word_q.size())
         else flag_error("decoder left upstream words unread");
      $display("test %s symbols %0d errors %0d", cur_test, test_syms, error_count - err_at_start);
      tests_run = tests_run + 1;
   endtask

   initial
   begin
      forever
      begin
         @(posedge clk);
         if (!reset && push)
         begin
            check_count = check_count + 1;
            assert (exp_q.size() != 0)
               else flag_error("push with no symbol left to expect");
            if (exp_q.size() != 0)
            begin
               exp_item = exp_q.pop_front();
               assert (symbol == exp_item[`HUF_SYM_W-1:0])
                  else report_mismatch("symbol", int'(exp_item[`HUF_SYM_W-1:0]), int'(symbol));
               assert (decode_error == exp_item[`HUF_SYM_W])
                  else report_mismatch("decode_error", int'(exp_item[`HUF_SYM_W]),
                                       int'(decode_error));
            end
            assert (nf_last)
               else flag_error("push after an EMIT cycle with not_full low");
         end
         else if (!reset)
            assert (!decode_error)
               else flag_error("decode_error pulsed without a push");
         nf_last = not_full;  // level the DUT saw during the cycle just ended
      end
   end

   initial
   begin
      while (cycle_count <= cycle_budget)
      begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("ERROR test=%s: run exceeded %0d cycles", cur_test, cycle_budget);
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      idle_after_reset();
      every_symbol_message();
      straddled_codes();
      random_backpressure();
      eom_with_padding();
      random_messages();
      $display("tests %0d checks %0d errors %0d", tests_run, check_count, error_count);
      if (error_count == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: verilog/huffman_stream_decoder.sv
`include "huffman_cfg.svh"

module huffman_stream_decoder
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic [`HUF_WORD_W-1:0]      word,          // upstream show-ahead data
   input  logic                        rdy,
   output logic                        pop,
   input  logic                        not_full,
   output logic                        push,
   output huffman_pkg::sym_t           symbol,
   output logic                        decode_error
);

   import huffman_pkg::*;

   seq_state_e               state;
   match_t                   match;
   logic [`HUF_MAX_CODE-1:0] head;
   bit_cnt_t                 bits_left;
   sym_t                     lookup_symbol;
   logic                     eom;
   logic                     refill;
   logic                     flush;

   decode_sequencer u_sequencer
   (
      .clk      (clk),
      .reset    (reset),
      .rdy      (rdy),
      .not_full (not_full),
      .eom      (eom),
      .refill   (refill),
      .pop      (pop),
      .state    (state)
   );

   bit_window u_window
   (
      .clk       (clk),
      .reset     (reset),
      .state     (state),
      .word      (word),
      .match     (match),
      .flush     (flush),
      .head      (head),
      .bits_left (bits_left)
   );

   code_matcher u_matcher
   (
      .clk   (clk),
      .reset (reset),
      .state (state),
      .head  (head),
      .match (match)
   );

   symbol_lookup u_lookup
   (
      .clk    (clk),
      .state  (state),
      .match  (match),
      .symbol (lookup_symbol)
   );

   symbol_emitter u_emitter
   (
      .clk          (clk),
      .reset        (reset),
      .state        (state),
      .not_full     (not_full),
      .symbol_in    (lookup_symbol),
      .bits_left    (bits_left),
      .push         (push),
      .symbol       (symbol),
      .eom          (eom),
      .refill       (refill),
      .flush        (flush),
      .decode_error (decode_error)
   );

   // a fetch is always separated from the last push by one IDLE cycle
   a_no_push_with_pop : assert property (@(posedge clk) disable iff (reset)
      !(push && pop));

endmodule

// File: verilog/symbol_emitter.sv
`include "huffman_cfg.svh"

module symbol_emitter
(
   input  logic                        clk,
   input  logic                        reset,
   input  huffman_pkg::seq_state_e     state,
   input  logic                        not_full,
   input  huffman_pkg::sym_t           symbol_in,
   input  huffman_pkg::bit_cnt_t       bits_left,
   output logic                        push,
   output huffman_pkg::sym_t           symbol,
   output logic                        eom,
   output logic                        refill,
   output logic                        flush,
   output logic                        decode_error
);

   import huffman_pkg::*;

   logic emit_now;

   assign emit_now = (state == EMIT) && not_full;
   assign eom      = symbol_in == sym_t'(`HUF_EOM);
   assign refill   = bits_left <= bit_cnt_t'(`HUF_REFILL_LIMIT);
   assign flush    = emit_now && eom;  // next message starts on a fresh word

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         push         <= 1'b0;
         decode_error <= 1'b0;
      end
      else
      begin
         push         <= emit_now;
         decode_error <= flush && (bits_left != '0);  // padding left after EOM
      end
   end

   always_ff @(posedge clk)
   begin
      if (emit_now)
      begin
         symbol <= symbol_in;
      end
   end

   a_push_after_emit : assert property (@(posedge clk) disable iff (reset)
      push |-> $past(state == EMIT && not_full));

endmodule

// File: huffman_core/symbol_lookup.sv
`include "huffman_cfg.svh"

module symbol_lookup
(
   input  logic                        clk,
   input  huffman_pkg::seq_state_e     state,
   input  huffman_pkg::match_t         match,
   output huffman_pkg::sym_t           symbol
);

   import huffman_pkg::*;

   sym_t sym_next;

   always_comb
   begin
      case (match.len)
         code_len_t'(2):
            sym_next = match.idx[0] ? sym_t'(7) : sym_t'(4);  // H : E
         code_len_t'(3):
            sym_next = match.idx[0] ? sym_t'(3) : sym_t'(0);  // D : A
         code_len_t'(4):
         begin
            case (match.idx)
               2'd0:    sym_next = sym_t'(2);  // C
               2'd1:    sym_next = sym_t'(5);  // F
               default: sym_next = sym_t'(6);  // G, idx 3 never occurs
            endcase
         end
         code_len_t'(5):
            sym_next = match.idx[0] ? sym_t'(`HUF_EOM) : sym_t'(1);  // EOM : B
         default:
            sym_next = sym_t'(0);
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (state == LOOKUP)
      begin
         symbol <= sym_next;
      end
   end

endmodule

// File: huffman_core/code_matcher.sv
`include "huffman_cfg.svh"

module code_matcher
(
   input  logic                        clk,
   input  logic                        reset,
   input  huffman_pkg::seq_state_e     state,
   input  logic [`HUF_MAX_CODE-1:0]    head,   // top window bits, MSB first
   output huffman_pkg::match_t         match
);

   import huffman_pkg::*;

   match_t match_next;

   // prefix classes of the fixed code, index bits follow the class prefix
   always_comb
   begin
      match_next = '0;
      casez (head)
         5'b0????:
         begin
            match_next.hit = 1'b1;  // E, H
            match_next.len = code_len_t'(2);
            match_next.idx = {1'b0, head[3]};
         end
         5'b10???:
         begin
            match_next.hit = 1'b1;  // A, D
            match_next.len = code_len_t'(3);
            match_next.idx = {1'b0, head[2]};
         end
         5'b110??, 5'b1110?:
         begin
            match_next.hit = 1'b1;  // C, F, G
            match_next.len = code_len_t'(4);
            match_next.idx = head[2:1];
         end
         5'b1111?:
         begin
            match_next.hit = 1'b1;  // B, EOM
            match_next.len = code_len_t'(5);
            match_next.idx = {1'b0, head[0]};
         end
         default:
         begin
            match_next = '0;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         match <= '0;
      end
      else if (state == MATCH)
      begin
         match <= match_next;
      end
   end

   a_hit_len : assert property (@(posedge clk) disable iff (reset)
      match.hit |-> (match.len >= code_len_t'(2)) && (match.len <= code_len_t'(`HUF_MAX_CODE)));

endmodule

// File: huffman_core/bit_window.sv
`include "huffman_cfg.svh"

module bit_window
(
   input  logic                        clk,
   input  logic                        reset,
   input  huffman_pkg::seq_state_e     state,
   input  logic [`HUF_WORD_W-1:0]      word,
   input  huffman_pkg::match_t         match,
   input  logic                        flush,      // drop everything on EOM
   output logic [`HUF_MAX_CODE-1:0]    head,
   output huffman_pkg::bit_cnt_t       bits_left
);

   import huffman_pkg::*;

   logic [`HUF_WIN_W-1:0] window;      // unread bits, left aligned
   logic [`HUF_WIN_W-1:0] word_ext;
   bit_cnt_t              load_shift;

   // the new word goes directly below the carried bits
   assign word_ext   = {{(`HUF_WIN_W-`HUF_WORD_W){1'b0}}, word};
   assign load_shift = bit_cnt_t'(`HUF_WIN_W - `HUF_WORD_W) - bits_left;

   assign head = window[`HUF_WIN_W-1 -: `HUF_MAX_CODE];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         window    <= '0;
         bits_left <= '0;
      end
      else if (flush)
      begin
         window    <= '0;  // rest of the word is padding
         bits_left <= '0;
      end
      else
      begin
         case (state)
            LOAD:
            begin
               window    <= window | (word_ext << load_shift);
               bits_left <= bits_left + bit_cnt_t'(`HUF_WORD_W);
            end
            LOOKUP:
            begin
               window    <= window << match.len;  // zeros fill from below
               bits_left <= bits_left - bit_cnt_t'(match.len);
            end
            default:
            begin
               window    <= window;
               bits_left <= bits_left;
            end
         endcase
      end
   end

   a_bits_in_range : assert property (@(posedge clk) disable iff (reset)
      bits_left <= bit_cnt_t'(`HUF_WIN_W));

   // the matcher must have classified the head before any shift happens
   a_lookup_has_hit : assert property (@(posedge clk) disable iff (reset)
      state == LOOKUP |-> match.hit);

endmodule

// File: huffman_core/decode_sequencer.sv
module decode_sequencer
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    rdy,       // upstream word available
   input  logic                    not_full,  // downstream has room
   input  logic                    eom,       // symbol in EMIT is end-of-message
   input  logic                    refill,    // window running low
   output logic                    pop,
   output huffman_pkg::seq_state_e state
);

   import huffman_pkg::*;

   seq_state_e next_state;
   logic       fetch;

   // start a fetch only when both FIFOs allow it
   assign fetch = (state == IDLE) && rdy && not_full;

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (fetch)
            begin
               next_state = LOAD;
            end
         end
         LOAD:
         begin
            next_state = MATCH;
         end
         MATCH:
         begin
            next_state = LOOKUP;
         end
         LOOKUP:
         begin
            next_state = EMIT;
         end
         EMIT:
         begin
            if (not_full)  // otherwise hold symbol and window
            begin
               if (eom || refill)
               begin
                  next_state = IDLE;
               end
               else
               begin
                  next_state = MATCH;
               end
            end
         end
         default:
         begin
            next_state = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= IDLE;
         pop   <= 1'b0;
      end
      else
      begin
         state <= next_state;
         pop   <= fetch;  // lines up with LOAD
      end
   end

   // the word is taken on the edge that ends LOAD, so pop must mark exactly that cycle
   a_pop_in_load : assert property (@(posedge clk) disable iff (reset)
      pop |-> state == LOAD);

endmodule

// File: common/huffman_pkg.sv
`include "huffman_cfg.svh"

package huffman_pkg;

   // one decoded symbol, A..H plus EOM
   typedef logic [`HUF_SYM_W-1:0] sym_t;

   // valid bits held in the window, 0 to 36
   typedef logic [$clog2(`HUF_WIN_W+1)-1:0] bit_cnt_t;

   // length of a matched code, 2 to 5
   typedef logic [$clog2(`HUF_MAX_CODE+1)-1:0] code_len_t;

   // result of classifying the window head
   typedef struct packed
   {
      logic      hit;  // a prefix class matched
      code_len_t len;  // bits to consume
      logic [1:0] idx; // entry within the class table
   } match_t;

   // decode sequence, one symbol in flight
   typedef enum logic [2:0]
   {
      IDLE,    // wait for a word and room downstream
      LOAD,    // pop strobe, merge word into window
      MATCH,   // classify head bits
      LOOKUP,  // shift window, look up symbol
      EMIT     // push symbol, pick next step
   } seq_state_e;

endpackage

// File: common/huffman_cfg.svh
`ifndef HUFFMAN_CFG_SVH
`define HUFFMAN_CFG_SVH

// packed input word from the upstream FIFO
`define HUF_WORD_W 32

// bit window is one word plus the bits carried over from the last one
`define HUF_WIN_W 36

// decoded symbol width
`define HUF_SYM_W 4

// longest prefix code, also the width of the window head
`define HUF_MAX_CODE 5

// end-of-message symbol value
`define HUF_EOM 8

// refill once the window holds this many bits or fewer
`define HUF_REFILL_LIMIT 4

`endif
